// ==== rtl/rv_decode_pkg.sv ====
`default_nettype none

package rv_decode_pkg;

   // Major opcode, instruction bits 6:2
   typedef enum logic [4:0] {
      OPC_LOAD   = 5'b00000,
      OPC_OP_IMM = 5'b00100,
      OPC_AUIPC  = 5'b00101,
      OPC_STORE  = 5'b01000,
      OPC_OP     = 5'b01100,
      OPC_LUI    = 5'b01101,
      OPC_BRANCH = 5'b11000,
      OPC_JALR   = 5'b11001,
      OPC_JAL    = 5'b11011,
      OPC_SYSTEM = 5'b11100
   } opcode_e;

   typedef enum logic [3:0] {
      ALU_ADD    = 4'd0,
      ALU_SUB    = 4'd1,
      ALU_SLL    = 4'd3,
      ALU_SLT    = 4'd4,
      ALU_SLTU   = 4'd5,
      ALU_XOR    = 4'd6,
      ALU_SRL    = 4'd7,
      ALU_SRA    = 4'd8,
      ALU_OR     = 4'd9,
      ALU_AND    = 4'd10,
      ALU_PASS_B = 4'd12
   } alu_op_e;

   // Same encoding as funct3 of the M extension
   typedef enum logic [2:0] {
      MDU_MUL    = 3'd0,
      MDU_MULH   = 3'd1,
      MDU_MULHSU = 3'd2,
      MDU_MULHU  = 3'd3,
      MDU_DIV    = 3'd4,
      MDU_DIVU   = 3'd5,
      MDU_REM    = 3'd6,
      MDU_REMU   = 3'd7
   } mdu_op_e;

   // Code 2 left free for a bit-manipulation unit
   typedef enum logic [1:0] {
      UNIT_ALU = 2'd0,
      UNIT_MDU = 2'd1,
      UNIT_CSR = 2'd3
   } unit_sel_e;

   typedef enum logic [1:0] {
      CSR_NONE  = 2'd0,
      CSR_WRITE = 2'd1,
      CSR_SET   = 2'd2,
      CSR_CLEAR = 2'd3
   } csr_op_e;

   typedef enum logic [1:0] {
      WB_EXEC     = 2'd0,
      WB_MEM      = 2'd1,
      WB_PC_PLUS4 = 2'd3
   } wb_sel_e;

   typedef enum logic [3:0] {
      EXC_NONE             = 4'd0,
      EXC_ILLEGAL          = 4'd2,
      EXC_BREAKPOINT       = 4'd3,
      EXC_LOAD_MISALIGNED  = 4'd4,
      EXC_STORE_MISALIGNED = 4'd6,
      EXC_ECALL_M          = 4'd11
   } exc_cause_e;

   typedef struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      opcode_e    opcode;
   } r_view_t;

   typedef struct packed {
      logic [11:0] funct12;
      logic [4:0]  rs1;
      logic [2:0]  funct3;
      logic [4:0]  rd;
      opcode_e     opcode;
   } i_view_t;

   // Instruction bits 31:2
   typedef union packed {
      r_view_t r_view;
      i_view_t i_view;
   } instr_u;

   typedef struct packed {
      logic       exc_valid;
      exc_cause_e exc_cause;
      logic       is_mret;
      unit_sel_e  unit_sel;
      logic       csr_en;
      csr_op_e    csr_op;
      logic       csr_src_imm;
      alu_op_e    alu_op;
      mdu_op_e    mdu_op;
      logic       rs2_negate;
      logic       reg_wr_en;
      wb_sel_e    wb_sel;
      logic       op1_pc;
      logic       op2_imm;
      logic       is_load;
      logic       is_store;
   } decode_ctrl_t;

   localparam decode_ctrl_t ILLEGAL_CTRL = '{
      exc_valid:   1'b1,
      exc_cause:   EXC_ILLEGAL,
      is_mret:     1'b0,
      unit_sel:    UNIT_ALU,
      csr_en:      1'b0,
      csr_op:      CSR_NONE,
      csr_src_imm: 1'b0,
      alu_op:      ALU_ADD,
      mdu_op:      MDU_MUL,
      rs2_negate:  1'b0,
      reg_wr_en:   1'b0,
      wb_sel:      WB_EXEC,
      op1_pc:      1'b0,
      op2_imm:     1'b0,
      is_load:     1'b0,
      is_store:    1'b0
   };

endpackage

`default_nettype wire

// ==== rtl/base_int_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module base_int_decoder
   import rv_decode_pkg::*;
(
   input  instr_u       instr_i,
   output logic         hit_o,
   output decode_ctrl_t ctrl_o
);

   localparam logic [6:0] F7_BASE = 7'b0000000;
   localparam logic [6:0] F7_ALT  = 7'b0100000;

   logic [2:0]   funct3;
   logic [6:0]   funct7;
   logic         hit;
   decode_ctrl_t ctrl;

   assign funct3 = instr_i.r_view.funct3;
   assign funct7 = instr_i.r_view.funct7;

   // Shared by the register-immediate and register-register forms
   function automatic alu_op_e funct3_alu_op(input logic [2:0] f3);
      alu_op_e op;
      case (f3)
         3'd0:    op = ALU_ADD;
         3'd1:    op = ALU_SLL;
         3'd2:    op = ALU_SLT;
         3'd3:    op = ALU_SLTU;
         3'd4:    op = ALU_XOR;
         3'd5:    op = ALU_SRL;
         3'd6:    op = ALU_OR;
         default: op = ALU_AND;
      endcase
      return op;
   endfunction

   always_comb begin
      hit  = 1'b0;
      ctrl = '0;
      case (instr_i.r_view.opcode)
         OPC_LOAD: begin
            hit            = funct3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            ctrl.exc_cause = EXC_LOAD_MISALIGNED;
            ctrl.alu_op    = ALU_ADD;
            ctrl.wb_sel    = WB_MEM;
            ctrl.op2_imm   = 1'b1;
            ctrl.is_load   = 1'b1;
            ctrl.reg_wr_en = 1'b1;
         end
         OPC_STORE: begin
            hit            = funct3 inside {3'd0, 3'd1, 3'd2};
            ctrl.exc_cause = EXC_STORE_MISALIGNED;
            ctrl.op2_imm   = 1'b1;
            ctrl.is_store  = 1'b1;
         end
         OPC_BRANCH: begin
            // Target computed as pc + imm
            hit          = !(funct3 inside {3'd2, 3'd3});
            ctrl.op1_pc  = 1'b1;
            ctrl.op2_imm = 1'b1;
            ctrl.alu_op  = ALU_ADD;
         end
         OPC_LUI: begin
            hit            = 1'b1;
            ctrl.alu_op    = ALU_PASS_B;
            ctrl.op2_imm   = 1'b1;
            ctrl.reg_wr_en = 1'b1;
         end
         OPC_AUIPC: begin
            hit            = 1'b1;
            ctrl.op1_pc    = 1'b1;
            ctrl.op2_imm   = 1'b1;
            ctrl.reg_wr_en = 1'b1;
         end
         OPC_JAL: begin
            hit            = 1'b1;
            ctrl.op1_pc    = 1'b1;
            ctrl.op2_imm   = 1'b1;
            ctrl.wb_sel    = WB_PC_PLUS4;
            ctrl.reg_wr_en = 1'b1;
         end
         OPC_JALR: begin
            hit            = (funct3 == 3'd0);
            ctrl.op2_imm   = 1'b1;
            ctrl.wb_sel    = WB_PC_PLUS4;
            ctrl.reg_wr_en = 1'b1;
         end
         OPC_OP_IMM: begin
            ctrl.op2_imm   = 1'b1;
            ctrl.reg_wr_en = 1'b1;
            ctrl.alu_op    = funct3_alu_op(funct3);
            case (funct3)
               3'd1: hit = (funct7 == F7_BASE);
               3'd5: begin
                  // Upper immediate bits pick logical or arithmetic shift
                  hit = (funct7 == F7_BASE) || (funct7 == F7_ALT);
                  if (funct7 == F7_ALT) begin
                     ctrl.alu_op = ALU_SRA;
                  end
               end
               default: hit = 1'b1;
            endcase
         end
         OPC_OP: begin
            ctrl.reg_wr_en = 1'b1;
            if (funct7 == F7_BASE) begin
               hit         = 1'b1;
               ctrl.alu_op = funct3_alu_op(funct3);
            end else if (funct7 == F7_ALT) begin
               if (funct3 == 3'd0) begin
                  hit             = 1'b1;
                  ctrl.alu_op     = ALU_SUB;
                  ctrl.rs2_negate = 1'b1;
               end else if (funct3 == 3'd5) begin
                  hit         = 1'b1;
                  ctrl.alu_op = ALU_SRA;
               end
            end
         end
         default: hit = 1'b0;
      endcase
   end

   assign hit_o  = hit;
   assign ctrl_o = hit ? ctrl : '0;

endmodule

`default_nettype wire

// ==== rtl/mul_div_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module mul_div_decoder
   import rv_decode_pkg::*;
(
   input  instr_u       instr_i,
   input  logic         m_en_i,
   output logic         hit_o,
   output decode_ctrl_t ctrl_o
);

   localparam logic [6:0] F7_MULDIV = 7'b0000001;

   logic hit;

   assign hit = m_en_i &&
                (instr_i.r_view.opcode == OPC_OP) &&
                (instr_i.r_view.funct7 == F7_MULDIV);

   always_comb begin
      ctrl_o = '0;
      if (hit) begin
         ctrl_o.unit_sel  = UNIT_MDU;
         // funct3 already is the MDU operation code
         ctrl_o.mdu_op    = mdu_op_e'(instr_i.r_view.funct3);
         ctrl_o.reg_wr_en = 1'b1;
      end
   end

   assign hit_o = hit;

endmodule

`default_nettype wire

// ==== rtl/system_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module system_decoder
   import rv_decode_pkg::*;
(
   input  instr_u       instr_i,
   output logic         hit_o,
   output decode_ctrl_t ctrl_o
);

   localparam logic [11:0] F12_ECALL  = 12'h000;
   localparam logic [11:0] F12_EBREAK = 12'h001;
   localparam logic [11:0] F12_WFI    = 12'h105;
   localparam logic [11:0] F12_MRET   = 12'h302;

   logic [2:0] funct3;
   logic       priv_form;

   assign funct3 = instr_i.i_view.funct3;

   // Privileged forms need rd and rs1 both zero
   assign priv_form = (funct3 == 3'd0) &&
                      (instr_i.i_view.rd == 5'd0) &&
                      (instr_i.i_view.rs1 == 5'd0);

   always_comb begin
      hit_o  = 1'b0;
      ctrl_o = '0;
      if (instr_i.i_view.opcode == OPC_SYSTEM) begin
         if (funct3[1:0] != 2'b00) begin
            // CSRRW/S/C and their immediate variants
            hit_o              = 1'b1;
            ctrl_o.unit_sel    = UNIT_CSR;
            ctrl_o.csr_en      = 1'b1;
            ctrl_o.reg_wr_en   = 1'b1;
            ctrl_o.csr_op      = csr_op_e'(funct3[1:0]);
            ctrl_o.csr_src_imm = funct3[2];
         end else if (priv_form) begin
            case (instr_i.i_view.funct12)
               F12_ECALL: begin
                  hit_o            = 1'b1;
                  ctrl_o.exc_valid = 1'b1;
                  ctrl_o.exc_cause = EXC_ECALL_M;
               end
               F12_EBREAK: begin
                  hit_o            = 1'b1;
                  ctrl_o.exc_valid = 1'b1;
                  ctrl_o.exc_cause = EXC_BREAKPOINT;
               end
               F12_MRET: begin
                  hit_o          = 1'b1;
                  ctrl_o.is_mret = 1'b1;
               end
               // Treated as a nop
               F12_WFI: hit_o = 1'b1;
               default: hit_o = 1'b0;
            endcase
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/decode_output_stage.sv ====
`timescale 1ns/1ps
`default_nettype none

module decode_output_stage
   import rv_decode_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  logic         valid_i,
   input  logic         base_hit_i,
   input  logic         mdu_hit_i,
   input  logic         sys_hit_i,
   input  decode_ctrl_t base_ctrl_i,
   input  decode_ctrl_t mdu_ctrl_i,
   input  decode_ctrl_t sys_ctrl_i,
   output logic         ctrl_valid_o,
   output decode_ctrl_t ctrl_o
);

   decode_ctrl_t ctrl_next;

   // Opcode spaces are disjoint so at most one hit is set
   always_comb begin
      if (base_hit_i) begin
         ctrl_next = base_ctrl_i;
      end else if (mdu_hit_i) begin
         ctrl_next = mdu_ctrl_i;
      end else if (sys_hit_i) begin
         ctrl_next = sys_ctrl_i;
      end else begin
         ctrl_next = ILLEGAL_CTRL;
      end
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_valid_o <= 1'b0;
         ctrl_o       <= '0;
      end else begin
         ctrl_valid_o <= valid_i;
         if (valid_i) begin
            ctrl_o <= ctrl_next;
         end
      end
   end

endmodule

`default_nettype wire

// ==== rtl/instr_decoder_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder_top
   import rv_decode_pkg::*;
(
   input  logic         clk_i,
   input  logic         rst_n_i,
   input  logic         instr_valid_i,
   input  instr_u       instr_i,
   input  logic         is_m_supported_i,
   output logic         ctrl_valid_o,
   output decode_ctrl_t ctrl_o
);

   logic         base_hit;
   logic         mdu_hit;
   logic         sys_hit;
   decode_ctrl_t base_ctrl;
   decode_ctrl_t mdu_ctrl;
   decode_ctrl_t sys_ctrl;

   base_int_decoder base_int_decoder_inst (
      .instr_i (instr_i),
      .hit_o   (base_hit),
      .ctrl_o  (base_ctrl)
   );

   mul_div_decoder mul_div_decoder_inst (
      .instr_i (instr_i),
      .m_en_i  (is_m_supported_i),
      .hit_o   (mdu_hit),
      .ctrl_o  (mdu_ctrl)
   );

   system_decoder system_decoder_inst (
      .instr_i (instr_i),
      .hit_o   (sys_hit),
      .ctrl_o  (sys_ctrl)
   );

   decode_output_stage decode_output_stage_inst (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .valid_i      (instr_valid_i),
      .base_hit_i   (base_hit),
      .mdu_hit_i    (mdu_hit),
      .sys_hit_i    (sys_hit),
      .base_ctrl_i  (base_ctrl),
      .mdu_ctrl_i   (mdu_ctrl),
      .sys_ctrl_i   (sys_ctrl),
      .ctrl_valid_o (ctrl_valid_o),
      .ctrl_o       (ctrl_o)
   );

endmodule

`default_nettype wire

// ==== testbench/instr_decoder_props.sv ====
`timescale 1ns/1ps
`default_nettype none

module instr_decoder_props
   import rv_decode_pkg::*;
(
   input logic         clk_i,
   input logic         rst_n_i,
   input logic         valid_i,
   input logic         ctrl_valid_i,
   input decode_ctrl_t ctrl_i
);

   // One cycle from strobe to output valid
   valid_follows_strobe: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      valid_i |=> ctrl_valid_i)
      else $error("ctrl_valid_o missing one cycle after valid_i");

   reset_clears_valid: assert property (@(posedge clk_i)
      !rst_n_i |=> !ctrl_valid_i)
      else $error("ctrl_valid_o high in the cycle after reset");

   // An excepting instruction must not touch registers or memory
   exc_blocks_side_effects: assert property (@(posedge clk_i) disable iff (!rst_n_i)
      ctrl_i.exc_valid |-> !(ctrl_i.reg_wr_en || ctrl_i.is_load || ctrl_i.is_store))
      else $error("exception together with write-back or memory access");

endmodule

bind decode_output_stage instr_decoder_props instr_decoder_props_inst (
   .clk_i        (clk_i),
   .rst_n_i      (rst_n_i),
   .valid_i      (valid_i),
   .ctrl_valid_i (ctrl_valid_o),
   .ctrl_i       (ctrl_o)
);

`default_nettype wire

// ==== testbench/tb_instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_instr_decoder
   import rv_decode_pkg::*;
();

   localparam int CLK_PERIOD      = 100;
   localparam int RESET_CYCLES    = 10;
   localparam int SEED            = 32'h3c97;
   localparam int STREAM_LEN      = 64;
   localparam int TEST_COUNT      = 220;
   localparam int CYCLES_PER_TEST = 4;
   localparam int WATCHDOG_TIME   =
      (TEST_COUNT * CYCLES_PER_TEST + RESET_CYCLES) * CLK_PERIOD;

   logic         clk;
   logic         rst_n;
   logic         instr_valid;
   instr_u       instr;
   logic         m_en;
   logic         ctrl_valid;
   decode_ctrl_t ctrl;
   integer       seed;
   int           ctrl_errors;
   int           valid_errors;

   instr_decoder_top instr_decoder_top_inst (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .instr_valid_i    (instr_valid),
      .instr_i          (instr),
      .is_m_supported_i (m_en),
      .ctrl_valid_o     (ctrl_valid),
      .ctrl_o           (ctrl)
   );

   always #(CLK_PERIOD / 2) clk = ~clk;

   function automatic logic [29:0] random_word();
      logic [31:0] r;
      r = $random(seed);
      return r[29:0];
   endfunction

   // Random registers and immediate around the given funct3 and opcode
   function automatic logic [29:0] rand_fields(input logic [2:0] f3, input logic [4:0] opc);
      logic [29:0] w;
      w = random_word();
      return {w[29:13], f3, w[9:5], opc};
   endfunction

   function automatic logic [29:0] r_word(input logic [6:0] f7, input logic [2:0] f3,
                                          input logic [4:0] opc);
      logic [29:0] w;
      w = random_word();
      return {f7, w[22:13], f3, w[9:5], opc};
   endfunction

   function automatic alu_op_e alu_from_funct3(input logic [2:0] f3, input logic alt);
      case (f3)
         3'd0:    return ALU_ADD;
         3'd1:    return ALU_SLL;
         3'd2:    return ALU_SLT;
         3'd3:    return ALU_SLTU;
         3'd4:    return ALU_XOR;
         3'd5:    return alt ? ALU_SRA : ALU_SRL;
         3'd6:    return ALU_OR;
         default: return ALU_AND;
      endcase
   endfunction

   // Reference model of the decode rules
   function automatic decode_ctrl_t expected_ctrl(input logic [29:0] w, input logic m);
      decode_ctrl_t c;
      logic [4:0]   opc;
      logic [4:0]   rd;
      logic [2:0]   f3;
      logic [4:0]   rs1;
      logic [6:0]   f7;
      logic [11:0]  f12;
      logic         legal;
      opc   = w[4:0];
      rd    = w[9:5];
      f3    = w[12:10];
      rs1   = w[17:13];
      f7    = w[29:23];
      f12   = w[29:18];
      c     = '0;
      legal = 1'b0;
      case (opc)
         OPC_LOAD: begin
            legal       = f3 inside {3'd0, 3'd1, 3'd2, 3'd4, 3'd5};
            c.exc_cause = EXC_LOAD_MISALIGNED;
            c.alu_op    = ALU_ADD;
            c.wb_sel    = WB_MEM;
            c.op2_imm   = 1'b1;
            c.is_load   = 1'b1;
            c.reg_wr_en = 1'b1;
         end
         OPC_STORE: begin
            legal       = (f3 < 3'd3);
            c.exc_cause = EXC_STORE_MISALIGNED;
            c.op2_imm   = 1'b1;
            c.is_store  = 1'b1;
         end
         OPC_BRANCH: begin
            legal     = (f3 != 3'd2) && (f3 != 3'd3);
            c.op1_pc  = 1'b1;
            c.op2_imm = 1'b1;
         end
         OPC_LUI: begin
            legal       = 1'b1;
            c.alu_op    = ALU_PASS_B;
            c.op2_imm   = 1'b1;
            c.reg_wr_en = 1'b1;
         end
         OPC_AUIPC: begin
            legal       = 1'b1;
            c.op1_pc    = 1'b1;
            c.op2_imm   = 1'b1;
            c.reg_wr_en = 1'b1;
         end
         OPC_JAL: begin
            legal       = 1'b1;
            c.op1_pc    = 1'b1;
            c.op2_imm   = 1'b1;
            c.wb_sel    = WB_PC_PLUS4;
            c.reg_wr_en = 1'b1;
         end
         OPC_JALR: begin
            legal       = (f3 == 3'd0);
            c.op2_imm   = 1'b1;
            c.wb_sel    = WB_PC_PLUS4;
            c.reg_wr_en = 1'b1;
         end
         OPC_OP_IMM: begin
            if (f3 == 3'd1) begin
               legal = (f7 == 7'd0);
            end else if (f3 == 3'd5) begin
               legal = (f7 == 7'd0) || (f7 == 7'd32);
            end else begin
               legal = 1'b1;
            end
            c.alu_op    = alu_from_funct3(f3, f7 == 7'd32);
            c.op2_imm   = 1'b1;
            c.reg_wr_en = 1'b1;
         end
         OPC_OP: begin
            c.reg_wr_en = 1'b1;
            if (f7 == 7'd0) begin
               legal    = 1'b1;
               c.alu_op = alu_from_funct3(f3, 1'b0);
            end else if (f7 == 7'd32 && f3 == 3'd0) begin
               legal        = 1'b1;
               c.alu_op     = ALU_SUB;
               c.rs2_negate = 1'b1;
            end else if (f7 == 7'd32 && f3 == 3'd5) begin
               legal    = 1'b1;
               c.alu_op = ALU_SRA;
            end else if (f7 == 7'd1 && m) begin
               legal      = 1'b1;
               c.unit_sel = UNIT_MDU;
               c.mdu_op   = mdu_op_e'(f3);
            end
         end
         OPC_SYSTEM: begin
            if (f3[1:0] != 2'd0) begin
               legal         = 1'b1;
               c.unit_sel    = UNIT_CSR;
               c.csr_en      = 1'b1;
               c.reg_wr_en   = 1'b1;
               c.csr_op      = csr_op_e'(f3[1:0]);
               c.csr_src_imm = f3[2];
            end else if (f3 == 3'd0 && rd == 5'd0 && rs1 == 5'd0) begin
               case (f12)
                  12'h000: begin
                     legal       = 1'b1;
                     c.exc_valid = 1'b1;
                     c.exc_cause = EXC_ECALL_M;
                  end
                  12'h001: begin
                     legal       = 1'b1;
                     c.exc_valid = 1'b1;
                     c.exc_cause = EXC_BREAKPOINT;
                  end
                  12'h302: begin
                     legal     = 1'b1;
                     c.is_mret = 1'b1;
                  end
                  12'h105: legal = 1'b1;
                  default: legal = 1'b0;
               endcase
            end
         end
         default: legal = 1'b0;
      endcase
      if (!legal) begin
         c           = '0;
         c.exc_valid = 1'b1;
         c.exc_cause = EXC_ILLEGAL;
      end
      return c;
   endfunction

   task automatic check_ctrl(input decode_ctrl_t got, input decode_ctrl_t exp,
                             input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s: ctrl_o %h, expected %h", $time, what, got, exp);
         ctrl_errors++;
      end
   endtask

   task automatic check_valid(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("[ERROR] %0t: %s: ctrl_valid_o %b, expected %b", $time, what, got, exp);
         valid_errors++;
      end
   endtask

   // Strobe one instruction and check it one cycle later
   task automatic decode_one(input logic [29:0] w, input logic m, input string what);
      decode_ctrl_t exp;
      string        msg;
      exp = expected_ctrl(w, m);
      msg = $sformatf("%s instr %h", what, w);
      @(negedge clk);
      instr       = w;
      m_en        = m;
      instr_valid = 1'b1;
      @(negedge clk);
      instr_valid = 1'b0;
      check_valid(ctrl_valid, 1'b1, msg);
      check_ctrl(ctrl, exp, msg);
   endtask

   task automatic test_reset_and_strobe();
      logic [29:0]  w;
      decode_ctrl_t exp;
      w   = rand_fields(3'd0, OPC_OP_IMM);
      exp = expected_ctrl(w, 1'b1);
      @(negedge clk);
      check_valid(ctrl_valid, 1'b0, "after reset");
      check_ctrl(ctrl, '0, "after reset");
      decode_one(w, 1'b1, "single strobe");
      // Unknown opcode at the decoders so only a held register matches
      instr = rand_fields(3'd7, 5'b11111);
      @(negedge clk);
      check_valid(ctrl_valid, 1'b0, "end of pulse");
      check_ctrl(ctrl, exp, "hold after pulse");
   endtask

   task automatic test_base_int();
      logic [29:0] w;
      for (int f3 = 0; f3 < 8; f3++) begin
         decode_one(rand_fields(3'(f3), OPC_LOAD), 1'b1, "load");
         decode_one(rand_fields(3'(f3), OPC_STORE), 1'b1, "store");
         decode_one(rand_fields(3'(f3), OPC_BRANCH), 1'b1, "branch");
         decode_one(rand_fields(3'(f3), OPC_JALR), 1'b1, "jalr");
         w = rand_fields(3'(f3), OPC_OP_IMM);
         decode_one({7'd0, w[22:0]}, 1'b1, "op_imm funct7 0");
         decode_one({7'd32, w[22:0]}, 1'b1, "op_imm funct7 32");
         decode_one(w, 1'b1, "op_imm random imm");
         decode_one(r_word(7'd0, 3'(f3), OPC_OP), 1'b1, "op funct7 0");
         decode_one(r_word(7'd32, 3'(f3), OPC_OP), 1'b1, "op funct7 32");
         decode_one(r_word(7'h40, 3'(f3), OPC_OP), 1'b1, "op funct7 64");
      end
      repeat (2) begin
         decode_one(rand_fields(3'(random_word()), OPC_LUI), 1'b1, "lui");
         decode_one(rand_fields(3'(random_word()), OPC_AUIPC), 1'b1, "auipc");
         decode_one(rand_fields(3'(random_word()), OPC_JAL), 1'b1, "jal");
      end
   endtask

   task automatic test_mul_div();
      for (int m = 0; m < 2; m++) begin
         for (int f3 = 0; f3 < 8; f3++) begin
            decode_one(r_word(7'd1, 3'(f3), OPC_OP), m == 1, "mul/div");
         end
      end
   endtask

   task automatic test_system();
      for (int f3 = 0; f3 < 8; f3++) begin
         decode_one(rand_fields(3'(f3), OPC_SYSTEM), 1'b1, "csr");
      end
      decode_one({12'h000, 5'd0, 3'd0, 5'd0, OPC_SYSTEM}, 1'b1, "ecall");
      decode_one({12'h001, 5'd0, 3'd0, 5'd0, OPC_SYSTEM}, 1'b1, "ebreak");
      decode_one({12'h302, 5'd0, 3'd0, 5'd0, OPC_SYSTEM}, 1'b1, "mret");
      decode_one({12'h105, 5'd0, 3'd0, 5'd0, OPC_SYSTEM}, 1'b1, "wfi");
      decode_one({12'h000, 5'd0, 3'd0, 5'd5, OPC_SYSTEM}, 1'b1, "ecall rd 5");
      decode_one({12'h001, 5'd3, 3'd0, 5'd0, OPC_SYSTEM}, 1'b1, "ebreak rs1 3");
      decode_one({12'h7b2, 5'd0, 3'd0, 5'd0, OPC_SYSTEM}, 1'b1, "unknown funct12");
   endtask

   task automatic test_illegal();
      decode_one(r_word(7'h20, 3'd7, OPC_OP), 1'b1, "andn");
      decode_one(r_word(7'h10, 3'd2, OPC_OP), 1'b1, "sh1add");
      decode_one(r_word(7'h05, 3'd4, OPC_OP), 1'b1, "min");
      decode_one(r_word(7'h30, 3'd1, OPC_OP), 1'b1, "rol");
      decode_one(r_word(7'h24, 3'd1, OPC_OP_IMM), 1'b1, "bclri");
      decode_one(r_word(7'h08, 3'd2, 5'b01011), 1'b1, "amo");
      decode_one(rand_fields(3'd0, 5'b00011), 1'b1, "fence");
      decode_one(rand_fields(3'd2, 5'b00001), 1'b1, "fp load");
      decode_one(rand_fields(3'd0, 5'b10100), 1'b1, "fp op");
      decode_one(rand_fields(3'd7, 5'b11111), 1'b1, "unknown opcode");
   endtask

   // Consecutive strobes with each result checked as the next one is driven
   task automatic test_stream();
      logic [4:0]   opc_pool [12] = '{OPC_LOAD, OPC_STORE, OPC_BRANCH, OPC_JALR,
                                      OPC_JAL, OPC_AUIPC, OPC_LUI, OPC_OP_IMM,
                                      OPC_OP, OPC_SYSTEM, 5'b01011, 5'b00011};
      logic [6:0]   f7_pool [4]   = '{7'd0, 7'd32, 7'd1, 7'h20};
      logic [11:0]  f12_pool [4]  = '{12'h000, 12'h001, 12'h302, 12'h105};
      logic [31:0]  r;
      logic [29:0]  w;
      logic         m;
      decode_ctrl_t exp_prev;
      string        msg;
      for (int i = 0; i < STREAM_LEN; i++) begin
         r = $random(seed);
         w = rand_fields(r[2:0], opc_pool[r[6:3] % 4'd12]);
         if (w[4:0] == OPC_OP) begin
            w[29:23] = f7_pool[r[9:8]];
         end else if (w[4:0] == OPC_SYSTEM && r[11]) begin
            w = {f12_pool[r[13:12]], 5'd0, 3'd0, 5'd0, OPC_SYSTEM};
         end
         m = r[10];
         @(negedge clk);
         if (i > 0) begin
            check_valid(ctrl_valid, 1'b1, msg);
            check_ctrl(ctrl, exp_prev, msg);
         end
         instr       = w;
         m_en        = m;
         instr_valid = 1'b1;
         exp_prev    = expected_ctrl(w, m);
         msg         = $sformatf("stream %0d instr %h", i, w);
      end
      @(negedge clk);
      instr_valid = 1'b0;
      check_valid(ctrl_valid, 1'b1, msg);
      check_ctrl(ctrl, exp_prev, msg);
      @(negedge clk);
      check_valid(ctrl_valid, 1'b0, "after stream");
   endtask

   initial begin
      #(WATCHDOG_TIME);
      $display("Timeout: the tests did not finish within %0d ns", WATCHDOG_TIME);
      $display("test failed");
      $finish;
   end

   initial begin
      clk          = 1'b0;
      rst_n        = 1'b0;
      instr_valid  = 1'b0;
      instr        = '0;
      m_en         = 1'b0;
      seed         = SEED;
      ctrl_errors  = 0;
      valid_errors = 0;
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;
      test_reset_and_strobe();
      test_base_int();
      test_mul_div();
      test_system();
      test_illegal();
      test_stream();
      $display("Errors: ctrl_o %0d, ctrl_valid_o %0d", ctrl_errors, valid_errors);
      if (ctrl_errors + valid_errors == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== compile.f ====
rtl/rv_decode_pkg.sv
rtl/base_int_decoder.sv
rtl/mul_div_decoder.sv
rtl/system_decoder.sv
rtl/decode_output_stage.sv
rtl/instr_decoder_top.sv
testbench/instr_decoder_props.sv
testbench/tb_instr_decoder.sv

// ==== Makefile ====
VERILATOR ?= verilator
TOP       ?= tb_instr_decoder
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	-$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "test failed" $(LOG); then \
		echo "Simulation FAILED"; exit 1; \
	elif grep -q "test passed" $(LOG); then \
		echo "Simulation PASSED"; \
	else \
		echo "Simulation ended without a result"; exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only --timing -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
